/* enhanced_router.f */
+incdir+.
router_pkg.sv
port_fifo.sv
route_decode.sv
fsm_crossbar.sv
enhanced_router.sv
tb_enhanced_router.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f enhanced_router.f \
    --top-module tb_enhanced_router \
    -o tb_enhanced_router

status=0
./obj_dir/tb_enhanced_router > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure (exit status ${status})"
    exit 1
fi

/* router_patterns.txt */
# phase port addr data gap expect (addr and data in hex, the rest decimal)
# data bits 15..13 hold the source port, expect is the output port
1 0 0c 0101 2 1
1 0 0d 0102 2 2
1 0 0e 0103 0 3
1 0 0f 0104 0 4
1 0 20 0105 0 1
1 0 3d 0106 3 2
1 0 13 0107 2 4
2 0 18 0201 1 0
2 0 19 0202 0 0
2 0 1a 0203 0 0
2 0 1b 0204 2 0
3 1 2a 2301 0 0
3 2 05 4302 0 0
3 3 18 6303 0 0
3 4 3f 8304 1 0
3 1 00 2305 0 0
3 4 11 8306 0 0
3 2 1b 4307 0 0
3 3 2c 6308 3 0
4 2 07 4401 0 0
4 2 07 4402 0 0
4 2 07 4403 0 0
4 2 07 4404 0 0
4 2 07 4405 0 0
4 2 07 4406 0 0
4 2 07 4407 0 0
4 2 07 4408 0 0
4 2 07 4409 0 0
5 0 0c 0501 0 1
5 1 01 2502 0 0
5 2 02 4503 0 0
5 3 03 6504 0 0
5 4 04 8505 0 0
5 0 18 0506 0 0
5 1 05 2507 0 0
5 2 06 4508 0 0
5 3 07 6509 0 0
5 4 08 850a 0 0
5 0 0f 050b 0 4
5 1 09 250c 0 0
5 2 0a 450d 0 0
5 3 0b 650e 0 0
5 4 0c 850f 0 0

/* tb_enhanced_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module tb_enhanced_router;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 10;
    localparam int WATCHDOG_SLACK = 200;
    localparam int HOLD_CYCLES    = 4;
    localparam int PHASE_OVERFLOW = 4;
    localparam int PHASE_FAIR     = 5;
    localparam int NP             = `ROUTER_NPORTS;
    localparam int MAX_LINES      = 64;

    logic                              clk;
    logic                              rst_n;
    logic                              arb_enable;
    logic [NP-1:0]                     in_valid;
    logic [`ROUTER_DWIDTH-1:0]         in_data [NP];
    logic [`ROUTER_AWIDTH-1:0]         in_addr [NP];
    wire  [NP-1:0][`ROUTER_DWIDTH-1:0] out_data;
    wire  [NP-1:0]                     out_valid;
    wire  [3:0]                        spine_fifo_in_full;
    wire  [3:0]                        spine_fifo_in_empty;
    wire                               gpu_fifo_in_full;
    wire                               gpu_fifo_in_empty;
    wire                               crossbar_busy;
    wire  [2:0]                        current_grant;
    wire  [1:0]                        routing_direction;

    int                        pat_phase [MAX_LINES];
    int                        pat_port  [MAX_LINES];
    int                        pat_gap   [MAX_LINES];
    logic [`ROUTER_AWIDTH-1:0] pat_addr  [MAX_LINES];
    logic [`ROUTER_DWIDTH-1:0] pat_data  [MAX_LINES];
    int                        num_lines       = 0;
    int                        gap_total       = 0;
    bit                        patterns_loaded = 1'b0;

    // expected words, indexed by destination * NP + source.
    logic [`ROUTER_DWIDTH-1:0] exp_q [NP*NP][$];
    int                        writes [NP];
    int                        grant_hist [$];
    int                        cur_phase    = 0;
    bit                        hold_active  = 1'b0;
    int                        value_errors = 0;
    int                        other_errors = 0;
    string                     pname [NP] = '{"gpu", "spine11", "spine21", "spine31", "spine41"};

    enhanced_router DUT (
        .clk                 (clk),
        .rst_n               (rst_n),
        .arb_enable          (arb_enable),
        .gpu_in_data         (in_data[0]),
        .gpu_in_valid        (in_valid[0]),
        .gpu_dest_addr       (in_addr[0]),
        .gpu_out_data        (out_data[0]),
        .gpu_out_valid       (out_valid[0]),
        .spine11_in_data     (in_data[1]),
        .spine11_in_valid    (in_valid[1]),
        .spine11_dest_addr   (in_addr[1]),
        .spine11_out_data    (out_data[1]),
        .spine11_out_valid   (out_valid[1]),
        .spine21_in_data     (in_data[2]),
        .spine21_in_valid    (in_valid[2]),
        .spine21_dest_addr   (in_addr[2]),
        .spine21_out_data    (out_data[2]),
        .spine21_out_valid   (out_valid[2]),
        .spine31_in_data     (in_data[3]),
        .spine31_in_valid    (in_valid[3]),
        .spine31_dest_addr   (in_addr[3]),
        .spine31_out_data    (out_data[3]),
        .spine31_out_valid   (out_valid[3]),
        .spine41_in_data     (in_data[4]),
        .spine41_in_valid    (in_valid[4]),
        .spine41_dest_addr   (in_addr[4]),
        .spine41_out_data    (out_data[4]),
        .spine41_out_valid   (out_valid[4]),
        .spine_fifo_in_full  (spine_fifo_in_full),
        .spine_fifo_in_empty (spine_fifo_in_empty),
        .gpu_fifo_in_full    (gpu_fifo_in_full),
        .gpu_fifo_in_empty   (gpu_fifo_in_empty),
        .crossbar_busy       (crossbar_busy),
        .current_grant       (current_grant),
        .routing_direction   (routing_direction)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // local group loops back, other GPU words go up, spine words go down.
    function automatic int decode_target(input int port, input logic [5:0] addr);
        if (port != 0 || addr[5:2] == `ROUTER_GROUP_ID) begin
            return 0;
        end
        return int'(addr[1:0]) + 1;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            value_errors++;
            $display("Fail at %0d ns: %s expected %0h, got %0h", $time, sig, exp_v, act_v);
        end
    endtask

    task automatic report_problem(input string what);
        other_errors++;
        $display("%s at %0d ns", what, $time);
    endtask

    task automatic print_summary();
        $display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    endtask

    task automatic load_patterns();
        int                        fd;
        int                        n;
        string                     line;
        int                        ph;
        int                        pt;
        int                        gp;
        int                        ex;
        logic [`ROUTER_AWIDTH-1:0] ad;
        logic [`ROUTER_DWIDTH-1:0] dt;
        fd = $fopen("router_patterns.txt", "r");
        assert (fd != 0) else report_problem("cannot open router_patterns.txt");
        while (fd != 0 && !$feof(fd) && num_lines < MAX_LINES) begin
            line = "";
            void'($fgets(line, fd));
            n = 0;
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %h %h %d %d", ph, pt, ad, dt, gp, ex);
            end
            if (n == 6) begin
                assert (pt < NP && int'(dt[15:13]) == pt && decode_target(pt, ad) == ex) else
                    report_problem($sformatf("pattern %0d disagrees with the routing rule",
                                             num_lines));
                pat_phase[num_lines] = ph;
                pat_port[num_lines]  = pt % NP;
                pat_gap[num_lines]   = gp;
                pat_addr[num_lines]  = ad;
                pat_data[num_lines]  = dt;
                gap_total += gp;
                num_lines++;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        patterns_loaded = 1'b1;
    endtask

    // every window of five grants must cover all ports.
    task automatic check_fairness(input int grant);
        logic [NP-1:0] seen;
        seen = '0;
        grant_hist.push_back(grant);
        if (grant_hist.size() > NP) begin
            void'(grant_hist.pop_front());
        end
        if (grant_hist.size() == NP) begin
            foreach (grant_hist[k]) begin
                seen[grant_hist[k]] = 1'b1;
            end
            assert (seen == '1) else report_problem("round-robin skipped a backlogged port");
        end
    endtask

    task automatic check_output(input int p);
        int src;
        int key;
        src = int'(out_data[p][15:13]);
        key = p * NP + src;
        assert (src < NP && exp_q[key].size() > 0) else
            report_problem($sformatf("unexpected word %h on %s_out_data", out_data[p], pname[p]));
        if (src < NP && exp_q[key].size() > 0) begin
            check_value({pname[p], "_out_data"}, exp_q[key].pop_front(), out_data[p]);
            check_value("current_grant", src, current_grant);
            check_value("routing_direction",
                        (p == 0) ? 32'(router_pkg::DIR_DOWN) : 32'(router_pkg::DIR_UP),
                        routing_direction);
            if (cur_phase == PHASE_FAIR) begin
                check_fairness(int'(current_grant));
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            assert ($onehot0(out_valid)) else report_problem("two output strobes in one cycle");
            assert (!(hold_active && out_valid != '0)) else
                report_problem("output strobe while arbitration was disabled");
            for (int p = 0; p < NP; p++) begin
                if (out_valid[p]) begin
                    check_output(p);
                end
            end
        end
    end

    // overflow and fairness phases queue everything with arbitration off.
    task automatic begin_phase(input int ph);
        cur_phase = ph;
        grant_hist.delete();
        foreach (writes[p]) begin
            writes[p] = 0;
        end
        @(posedge clk);
        arb_enable <= !(ph == PHASE_OVERFLOW || ph == PHASE_FAIR);
        @(posedge clk);
        hold_active = !arb_enable;
    endtask

    task automatic send_word(input int i);
        int p;
        p = pat_port[i];
        @(posedge clk);
        in_valid    <= '0;
        in_valid[p] <= 1'b1;
        in_data[p]  <= pat_data[i];
        in_addr[p]  <= pat_addr[i];
        exp_q[decode_target(p, pat_addr[i]) * NP + p].push_back(pat_data[i]);
        writes[p]++;
        repeat (pat_gap[i]) begin
            @(posedge clk);
            in_valid <= '0;
        end
    endtask

    task automatic finish_phase();
        int left;
        int drops;
        left  = 0;
        drops = 0;
        @(posedge clk);
        in_valid <= '0;
        if (hold_active) begin
            repeat (HOLD_CYCLES) @(posedge clk);
            @(negedge clk);
            // queued words alone do not make the crossbar busy.
            check_value("crossbar_busy", 0, crossbar_busy);
            for (int p = 0; p < NP; p++) begin
                check_value((p == 0) ? "gpu_fifo_in_full" :
                            $sformatf("spine_fifo_in_full[%0d]", p - 1),
                            writes[p] >= `ROUTER_FIFO_DEPTH,
                            (p == 0) ? gpu_fifo_in_full : spine_fifo_in_full[(p + 3) % 4]);
                if (writes[p] >= `ROUTER_FIFO_DEPTH) begin
                    drops += writes[p] - `ROUTER_FIFO_DEPTH;
                end
            end
            hold_active = 1'b0;
        end
        @(posedge clk);
        arb_enable <= 1'b1;
        do begin
            @(negedge clk);
        end while (!(gpu_fifo_in_empty && spine_fifo_in_empty == '1 && !crossbar_busy));
        repeat (2) @(negedge clk);
        for (int k = 0; k < NP * NP; k++) begin
            while (exp_q[k].size() > 0) begin
                $display("word %h from %s never seen on %s_out_data",
                         exp_q[k].pop_front(), pname[k % NP], pname[k / NP]);
                left++;
            end
        end
        assert (left == drops) else
            report_problem($sformatf("%0d words missing where overflow explains %0d", left, drops));
    endtask

    initial begin
        rst_n      = 1'b0;
        arb_enable = 1'b0;
        in_valid   = '0;
        foreach (in_data[p]) begin
            in_data[p] = '0;
            in_addr[p] = '0;
        end
        load_patterns();
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("out_valid", 0, out_valid);
        check_value("spine_fifo_in_empty", 4'hf, spine_fifo_in_empty);
        check_value("gpu_fifo_in_empty", 1, gpu_fifo_in_empty);
        check_value("crossbar_busy", 0, crossbar_busy);
        check_value("routing_direction", router_pkg::DIR_IDLE, routing_direction);
        check_value("current_grant", router_pkg::PORT_GPU, current_grant);
        for (int i = 0; i < num_lines; i++) begin
            if (pat_phase[i] != cur_phase) begin
                if (cur_phase != 0) begin
                    finish_phase();
                end
                begin_phase(pat_phase[i]);
            end
            send_word(i);
        end
        if (cur_phase != 0) begin
            finish_phase();
        end
        print_summary();
        if (value_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (patterns_loaded);
        #((gap_total + WATCHDOG_SLACK) * CLK_PERIOD);
        report_problem("watchdog expired before all phases finished");
        print_summary();
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* enhanced_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module enhanced_router (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         arb_enable,

    input  wire  [`ROUTER_DWIDTH-1:0]   gpu_in_data,
    input  wire                         gpu_in_valid,
    input  wire  [`ROUTER_AWIDTH-1:0]   gpu_dest_addr,
    output wire  [`ROUTER_DWIDTH-1:0]   gpu_out_data,
    output wire                         gpu_out_valid,

    input  wire  [`ROUTER_DWIDTH-1:0]   spine11_in_data,
    input  wire                         spine11_in_valid,
    input  wire  [`ROUTER_AWIDTH-1:0]   spine11_dest_addr,
    output wire  [`ROUTER_DWIDTH-1:0]   spine11_out_data,
    output wire                         spine11_out_valid,

    input  wire  [`ROUTER_DWIDTH-1:0]   spine21_in_data,
    input  wire                         spine21_in_valid,
    input  wire  [`ROUTER_AWIDTH-1:0]   spine21_dest_addr,
    output wire  [`ROUTER_DWIDTH-1:0]   spine21_out_data,
    output wire                         spine21_out_valid,

    input  wire  [`ROUTER_DWIDTH-1:0]   spine31_in_data,
    input  wire                         spine31_in_valid,
    input  wire  [`ROUTER_AWIDTH-1:0]   spine31_dest_addr,
    output wire  [`ROUTER_DWIDTH-1:0]   spine31_out_data,
    output wire                         spine31_out_valid,

    input  wire  [`ROUTER_DWIDTH-1:0]   spine41_in_data,
    input  wire                         spine41_in_valid,
    input  wire  [`ROUTER_AWIDTH-1:0]   spine41_dest_addr,
    output wire  [`ROUTER_DWIDTH-1:0]   spine41_out_data,
    output wire                         spine41_out_valid,

    output wire  [3:0]                  spine_fifo_in_full,
    output wire  [3:0]                  spine_fifo_in_empty,
    output wire                         gpu_fifo_in_full,
    output wire                         gpu_fifo_in_empty,

    output wire                         crossbar_busy,
    output wire router_pkg::port_idx_e  current_grant,
    output wire router_pkg::dir_e       routing_direction
);

    localparam int NP = `ROUTER_NPORTS;

    wire [NP-1:0][`ROUTER_DWIDTH-1:0]     in_data;
    wire [NP-1:0][`ROUTER_AWIDTH-1:0]     in_addr;
    wire [NP-1:0]                         in_valid;
    wire router_pkg::flit_t [NP-1:0]      head_flit;
    wire [NP-1:0][`ROUTER_DWIDTH-1:0]     head_data;
    wire router_pkg::port_idx_e [NP-1:0]  head_target;
    wire router_pkg::dir_e [NP-1:0]       head_dir;
    wire [NP-1:0]                         fifo_full;
    wire [NP-1:0]                         fifo_empty;
    wire [NP-1:0]                         pop;
    wire [NP-1:0][`ROUTER_DWIDTH-1:0]     out_data;
    wire [NP-1:0]                         out_valid;

    // index 0 is the GPU, 1 to 4 the spines.
    assign in_data  = {spine41_in_data, spine31_in_data, spine21_in_data,
                       spine11_in_data, gpu_in_data};
    assign in_addr  = {spine41_dest_addr, spine31_dest_addr, spine21_dest_addr,
                       spine11_dest_addr, gpu_dest_addr};
    assign in_valid = {spine41_in_valid, spine31_in_valid, spine21_in_valid,
                       spine11_in_valid, gpu_in_valid};

    for (genvar i = 0; i < NP; i++) begin : g_port
        port_fifo #(
            .entry_t (router_pkg::flit_t),
            .DEPTH   (`ROUTER_FIFO_DEPTH)
        ) u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr_en   (in_valid[i]),
            .wr_data ({in_data[i], in_addr[i]}),
            .rd_en   (pop[i]),
            .rd_data (head_flit[i]),
            .full    (fifo_full[i]),
            .empty   (fifo_empty[i])
        );

        assign head_data[i] = head_flit[i].data;

        route_decode #(
            .FROM_SPINE (i != 0)
        ) u_decode (
            .dest_addr (head_flit[i].addr),
            .target    (head_target[i]),
            .dir       (head_dir[i])
        );
    end

    fsm_crossbar u_crossbar (
        .clk           (clk),
        .rst_n         (rst_n),
        .arb_enable    (arb_enable),
        .head_data     (head_data),
        .head_target   (head_target),
        .head_dir      (head_dir),
        .fifo_empty    (fifo_empty),
        .pop           (pop),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .busy          (crossbar_busy),
        .current_grant (current_grant),
        .direction     (routing_direction)
    );

    assign gpu_out_data      = out_data[0];
    assign gpu_out_valid     = out_valid[0];
    assign spine11_out_data  = out_data[1];
    assign spine11_out_valid = out_valid[1];
    assign spine21_out_data  = out_data[2];
    assign spine21_out_valid = out_valid[2];
    assign spine31_out_data  = out_data[3];
    assign spine31_out_valid = out_valid[3];
    assign spine41_out_data  = out_data[4];
    assign spine41_out_valid = out_valid[4];

    assign gpu_fifo_in_full    = fifo_full[0];
    assign gpu_fifo_in_empty   = fifo_empty[0];
    assign spine_fifo_in_full  = fifo_full[4:1];
    assign spine_fifo_in_empty = fifo_empty[4:1];

endmodule

`default_nettype wire

/* fsm_crossbar.sv */
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module fsm_crossbar (
    input  wire                                                  clk,
    input  wire                                                  rst_n,
    input  wire                                                  arb_enable,
    input  wire [`ROUTER_NPORTS-1:0][`ROUTER_DWIDTH-1:0]         head_data,
    input  wire router_pkg::port_idx_e [`ROUTER_NPORTS-1:0]      head_target,
    input  wire router_pkg::dir_e [`ROUTER_NPORTS-1:0]           head_dir,
    input  wire [`ROUTER_NPORTS-1:0]                             fifo_empty,
    output logic [`ROUTER_NPORTS-1:0]                            pop,
    output logic [`ROUTER_NPORTS-1:0][`ROUTER_DWIDTH-1:0]        out_data,
    output logic [`ROUTER_NPORTS-1:0]                            out_valid,
    output logic                                                 busy,
    output router_pkg::port_idx_e                                current_grant,
    output router_pkg::dir_e                                     direction
);

    localparam int NP = `ROUTER_NPORTS;
    localparam int PW = `ROUTER_PWIDTH;

    typedef enum logic {
        ST_IDLE,
        ST_GRANT
    } state_e;

    state_e                state;
    state_e                state_nxt;
    logic                  any_ready;
    logic                  grant_fire;
    router_pkg::port_idx_e pick;
    router_pkg::port_idx_e pick_target;
    logic [NP-1:0]         target_onehot;

    // first non-empty port after the last grant, wrapping at NP.
    function automatic router_pkg::port_idx_e rr_pick(
        input logic [PW-1:0] last,
        input logic [NP-1:0] empty
    );
        logic [PW-1:0] idx;
        logic [PW-1:0] sel;
        logic          found;
        idx   = last;
        sel   = last;
        found = 1'b0;
        for (int k = 0; k < NP; k++) begin
            idx = (idx == PW'(NP - 1)) ? '0 : idx + 1'b1;
            if (!found && !empty[idx]) begin
                sel   = idx;
                found = 1'b1;
            end
        end
        return router_pkg::port_idx_e'(sel);
    endfunction

    assign any_ready = arb_enable && (fifo_empty != '1);
    assign busy      = any_ready;

    // one word per cycle while granting.
    assign grant_fire    = (state == ST_GRANT) && any_ready;
    assign pick          = rr_pick(current_grant, fifo_empty);
    assign pick_target   = head_target[pick];
    assign target_onehot = NP'(1) << pick_target;
    assign pop           = grant_fire ? (NP'(1) << pick) : '0;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (any_ready) begin
                    state_nxt = ST_GRANT;
                end
            end
            ST_GRANT: begin
                if (!any_ready) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            out_valid     <= '0;
            current_grant <= router_pkg::PORT_GPU;
            direction     <= router_pkg::DIR_IDLE;
        end else begin
            state     <= state_nxt;
            out_valid <= grant_fire ? target_onehot : '0;
            // direction follows the strobe it belongs to.
            direction <= grant_fire ? head_dir[pick] : router_pkg::DIR_IDLE;
            if (grant_fire) begin
                current_grant <= pick;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int t = 0; t < NP; t++) begin
            if (grant_fire && target_onehot[t]) begin
                out_data[t] <= head_data[pick];
            end
        end
    end

    a_pop_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(pop));

    // a popped port must still hold a word.
    a_pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        (pop & fifo_empty) == '0);

endmodule

`default_nettype wire

/* route_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module route_decode #(
    parameter bit FROM_SPINE = 1'b0
) (
    input  wire  [`ROUTER_AWIDTH-1:0] dest_addr,
    output router_pkg::port_idx_e     target,
    output router_pkg::dir_e          dir
);

    logic [3:0]                group_field;
    logic [1:0]                spine_sel;
    logic [`ROUTER_PWIDTH-1:0] spine_port;

    assign group_field = dest_addr[5:2];
    assign spine_sel   = dest_addr[1:0];

    // spine ports start at index 1.
    assign spine_port = {1'b0, spine_sel} + `ROUTER_PWIDTH'(1);

    always_comb begin
        target = router_pkg::PORT_GPU;
        dir    = router_pkg::DIR_DOWN;
        if (!FROM_SPINE) begin
            if (group_field != `ROUTER_GROUP_ID) begin
                // foreign group goes up.
                target = router_pkg::port_idx_e'(spine_port);
                dir    = router_pkg::DIR_UP;
            end
        end
    end

endmodule

`default_nettype wire

/* port_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "router_settings.svh"

module port_fifo #(
    parameter type entry_t = router_pkg::flit_t,
    parameter int  DEPTH   = `ROUTER_FIFO_DEPTH
) (
    input  wire    clk,
    input  wire    rst_n,
    input  wire    wr_en,
    input  wire    entry_t wr_data,
    input  wire    rd_en,
    output entry_t rd_data,
    output logic   full,
    output logic   empty
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    entry_t        mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == CW'(DEPTH));
    assign empty = (count == '0);

    // a write into a full buffer is dropped.
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // head is visible without a read cycle.
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the reader must never pop an empty buffer.
    a_no_read_empty: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en |-> !empty);

    // overflow loses the word and keeps the level.
    a_overflow_drop: assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && full && !rd_en) |=> (count == $past(count)));

endmodule

`default_nettype wire

/* router_pkg.sv */
`default_nettype none

`include "router_settings.svh"

package router_pkg;

    // output and grant index.
    typedef enum logic [2:0] {
        PORT_GPU    = 3'd0,
        PORT_SPINE1 = 3'd1,
        PORT_SPINE2 = 3'd2,
        PORT_SPINE3 = 3'd3,
        PORT_SPINE4 = 3'd4
    } port_idx_e;

    // routing direction of the forwarded word.
    typedef enum logic [1:0] {
        DIR_IDLE = 2'd0,
        DIR_UP   = 2'd1,
        DIR_DOWN = 2'd2
    } dir_e;

    // one queued word.
    typedef struct packed {
        logic [`ROUTER_DWIDTH-1:0] data;
        logic [`ROUTER_AWIDTH-1:0] addr;
    } flit_t;

endpackage

`default_nettype wire

/* router_settings.svh */
`ifndef ROUTER_SETTINGS_SVH
`define ROUTER_SETTINGS_SVH

// payload word width.
`define ROUTER_DWIDTH 16

// destination address, group field in bits 5..2 and spine select in 1..0.
`define ROUTER_AWIDTH 6

// entries per input FIFO.
`define ROUTER_FIFO_DEPTH 8

// group served by this leaf router.
`define ROUTER_GROUP_ID 4'b0110

// one GPU port plus four spine ports.
`define ROUTER_NPORTS 5

// width of a port index.
`define ROUTER_PWIDTH 3

`endif
